// File: tb.f
verilog/axi_pkg.sv
verilog/buffer_pkg.sv
verilog/axi_write_engine.sv
verilog/buffer_bank.sv
verilog/axi_read_engine.sv
verilog/axi_burst_buffer.sv
test/axi_burst_buffer_properties.sv
test/tb_axi_burst_buffer.sv

// File: Makefile
# Verilator build and run for the AXI burst buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_burst_buffer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_axi_burst_buffer.sv
`timescale 1ns/1ps

module tb_axi_burst_buffer
  import axi_pkg::*, buffer_pkg::*;
;

  // tests need a few hundred cycles, this leaves ample margin
  localparam int max_cycles = 4000;

  logic              aclk = 1'b0;
  logic              aresetn;
  buf_addr_t         aw_addr;
  logic [len_w-1:0]  aw_len;
  burst_t            aw_burst;
  logic [id_w-1:0]   aw_id;
  logic              aw_valid;
  logic              aw_ready;
  logic [data_w-1:0] w_data;
  logic              w_last;
  logic              w_valid;
  logic              w_ready;
  resp_t             b_resp;
  logic [id_w-1:0]   b_id;
  logic              b_valid;
  logic              b_ready;
  buf_addr_t         ar_addr;
  logic [len_w-1:0]  ar_len;
  burst_t            ar_burst;
  logic [id_w-1:0]   ar_id;
  logic              ar_valid;
  logic              ar_ready;
  logic [data_w-1:0] r_data;
  resp_t             r_resp;
  logic              r_last;
  logic [id_w-1:0]   r_id;
  logic              r_valid;
  logic              r_ready;

  // reference memory, one word per beat address (bits 11..2)
  logic [data_w-1:0] model [1024];
  logic [data_w-1:0] wdata_q [$];
  logic [data_w-1:0] rdata_q [$];
  time               ar_accept_time;
  time               b_done_time;
  int                cycle_count = 0;

  axi_burst_buffer i_dut (.*);

  always #50 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count++;
    if (i_dut.i_props.fail_count != 0) begin
      $display("bound assertion failed before %0t", $time);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end else if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  // next beat address as the AXI burst rules define it
  function automatic logic [15:0] model_next_addr(input logic [15:0] a, input burst_t burst,
                                                  input int beats);
    logic [15:0] nxt;
    logic [15:0] base;
    int          blk;
    nxt = {a[15:2], 2'b00} + 16'd4;
    if (burst == burst_fixed) begin
      return a;
    end
    if (burst == burst_wrap) begin
      blk  = beats * beat_bytes;
      base = a - 16'(int'(a) % blk);
      if (nxt == base + 16'(blk)) begin
        nxt = base;
      end
    end
    return nxt;
  endfunction

  task automatic check_data(input string name, input logic [data_w-1:0] expected,
                            input logic [data_w-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_id(input string name, input logic [id_w-1:0] expected,
                          input logic [id_w-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic write_burst(input logic [15:0] addr, input burst_t burst, input int beats,
                             input logic [id_w-1:0] id, input bit stall);
    buf_addr_t         a;
    logic [data_w-1:0] word;
    int                gap;
    a.flat = addr;
    wdata_q.delete();
    aw_addr.flat = addr;
    aw_len       = len_w'(beats - 1);
    aw_burst     = burst;
    aw_id        = id;
    aw_valid     = 1'b1;
    // ready seen at a falling edge means the transfer happens at the next rise
    while (!aw_ready) @(negedge aclk);
    @(negedge aclk);
    aw_valid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      if (stall) begin
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge aclk);
      end
      word    = $urandom;
      w_data  = word;
      w_last  = (i == beats - 1);
      w_valid = 1'b1;
      while (!w_ready) @(negedge aclk);
      @(negedge aclk);
      w_valid = 1'b0;
      w_last  = 1'b0;
      model[{a.f.row, a.f.bank}] = word;
      wdata_q.push_back(word);
      a.flat = model_next_addr(a.flat, burst, beats);
    end
    while (!b_valid) @(negedge aclk);
    if (stall) begin
      gap = $urandom_range(1, 4);
      repeat (gap) @(negedge aclk);
    end
    check_flag("b_valid", 1'b1, b_valid);
    check_resp("b_resp", resp_okay, b_resp);
    check_id("b_id", id, b_id);
    b_ready = 1'b1;
    @(negedge aclk);
    b_ready     = 1'b0;
    b_done_time = $time;
  endtask

  task automatic read_burst(input logic [15:0] addr, input burst_t burst, input int beats,
                            input logic [id_w-1:0] id, input bit stall);
    buf_addr_t a;
    int        gap;
    a.flat = addr;
    rdata_q.delete();
    ar_addr.flat = addr;
    ar_len       = len_w'(beats - 1);
    ar_burst     = burst;
    ar_id        = id;
    ar_valid     = 1'b1;
    while (!ar_ready) @(negedge aclk);
    ar_accept_time = $time;
    @(negedge aclk);
    ar_valid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      while (!r_valid) @(negedge aclk);
      if (stall) begin
        gap = $urandom_range(0, 4);
        repeat (gap) @(negedge aclk);
      end
      check_flag("r_valid", 1'b1, r_valid);
      check_data("r_data", model[{a.f.row, a.f.bank}], r_data);
      check_flag("r_last", i == beats - 1, r_last);
      check_id("r_id", id, r_id);
      check_resp("r_resp", resp_okay, r_resp);
      rdata_q.push_back(r_data);
      r_ready = 1'b1;
      @(negedge aclk);
      r_ready = 1'b0;
      a.flat  = model_next_addr(a.flat, burst, beats);
    end
  endtask

  task automatic run_incr_roundtrip();
    write_burst(16'h0040, burst_incr, 8, 4'h3, 1'b0);
    read_burst(16'h0040, burst_incr, 8, 4'h9, 1'b0);
  endtask

  task automatic run_wrap_write();
    write_burst(16'h0108, burst_wrap, 4, 4'h1, 1'b0);
    read_burst(16'h0100, burst_incr, 4, 4'h2, 1'b0);
    // words sit at 0x108, 0x10c, 0x100, 0x104
    check_data("wrap word 0x100", wdata_q[2], rdata_q[0]);
    check_data("wrap word 0x104", wdata_q[3], rdata_q[1]);
    check_data("wrap word 0x108", wdata_q[0], rdata_q[2]);
    check_data("wrap word 0x10c", wdata_q[1], rdata_q[3]);
  endtask

  task automatic run_fixed_write();
    write_burst(16'h0200, burst_fixed, 3, 4'h4, 1'b0);
    read_burst(16'h0200, burst_incr, 1, 4'h8, 1'b0);
    check_data("fixed last word", wdata_q[2], rdata_q[0]);
  endtask

  task automatic run_backpressure();
    write_burst(16'h0300, burst_incr, 16, 4'ha, 1'b1);
    read_burst(16'h0300, burst_incr, 16, 4'hb, 1'b1);
    read_burst(16'h0308, burst_wrap, 8, 4'hc, 1'b1);
  endtask

  task automatic run_priority_alias();
    // old word first so the read can tell old from new
    write_burst(16'h0500, burst_incr, 1, 4'h5, 1'b0);
    fork
      write_burst(16'h0500, burst_incr, 1, 4'h6, 1'b0);
      read_burst(16'h0500, burst_incr, 1, 4'h7, 1'b0);
    join
    check_flag("read accepted after write response", 1'b1, ar_accept_time > b_done_time);
    check_data("r_data after tie", wdata_q[0], rdata_q[0]);
    read_burst(16'h1500, burst_incr, 1, 4'h7, 1'b0);
    check_data("r_data alias 0x1500", wdata_q[0], rdata_q[0]);
  endtask

  initial begin
    void'($urandom(32'hbaf9));
    aresetn      = 1'b0;
    aw_addr.flat = '0;
    aw_len       = '0;
    aw_burst     = burst_incr;
    aw_id        = '0;
    aw_valid     = 1'b0;
    w_data       = '0;
    w_last       = 1'b0;
    w_valid      = 1'b0;
    b_ready      = 1'b0;
    ar_addr.flat = '0;
    ar_len       = '0;
    ar_burst     = burst_incr;
    ar_id        = '0;
    ar_valid     = 1'b0;
    r_ready      = 1'b0;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    check_flag("aw_ready after reset", 1'b0, aw_ready);
    check_flag("w_ready after reset", 1'b0, w_ready);
    check_flag("b_valid after reset", 1'b0, b_valid);
    check_flag("ar_ready after reset", 1'b0, ar_ready);
    check_flag("r_valid after reset", 1'b0, r_valid);
    check_flag("r_last after reset", 1'b0, r_last);
    run_incr_roundtrip();
    run_wrap_write();
    run_fixed_write();
    run_backpressure();
    run_priority_alias();
    repeat (2) @(negedge aclk);
    if (i_dut.i_props.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", i_dut.i_props.fail_count);
      $display("RESULT: FAIL");
      $fatal(1, "bound assertion failure");
    end
  end

endmodule

// File: test/axi_burst_buffer_properties.sv
`timescale 1ns/1ps

module axi_burst_buffer_properties
  import axi_pkg::*;
(
  input logic              aclk,
  input logic              aresetn,
  input logic              aw_ready,
  input logic              ar_ready,
  input logic              w_ready,
  input logic              b_valid,
  input logic              b_ready,
  input logic              r_valid,
  input logic              r_ready,
  input logic [data_w-1:0] r_data
);

  // number of failed assertions so far
  int fail_count = 0;

  // the two address channels are never accepted together
  a_aw_ar_excl: assert property (@(posedge aclk) disable iff (!aresetn)
    !(aw_ready && ar_ready))
    else begin
      $error("aw_ready and ar_ready high in the same cycle");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    r_valid && !r_ready |=> r_valid && $stable(r_data))
    else begin
      $error("r_valid dropped or r_data changed before r_ready");
      fail_count++;
    end

  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    b_valid && !b_ready |=> b_valid)
    else begin
      $error("b_valid dropped before b_ready");
      fail_count++;
    end

  // a write burst and read data never overlap
  a_w_r_excl: assert property (@(posedge aclk) disable iff (!aresetn)
    !(w_ready && r_valid))
    else begin
      $error("w_ready and r_valid high in the same cycle");
      fail_count++;
    end

endmodule

bind axi_burst_buffer axi_burst_buffer_properties i_props (.*);

// File: verilog/axi_burst_buffer.sv
`timescale 1ns/1ps

module axi_burst_buffer
  import axi_pkg::*, buffer_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  input  buf_addr_t         aw_addr,
  input  logic [len_w-1:0]  aw_len,
  input  burst_t            aw_burst,
  input  logic [id_w-1:0]   aw_id,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  logic [data_w-1:0] w_data,
  input  logic              w_last,
  input  logic              w_valid,
  output logic              w_ready,
  output resp_t             b_resp,
  output logic [id_w-1:0]   b_id,
  output logic              b_valid,
  input  logic              b_ready,
  input  buf_addr_t         ar_addr,
  input  logic [len_w-1:0]  ar_len,
  input  burst_t            ar_burst,
  input  logic [id_w-1:0]   ar_id,
  input  logic              ar_valid,
  output logic              ar_ready,
  output logic [data_w-1:0] r_data,
  output resp_t             r_resp,
  output logic              r_last,
  output logic [id_w-1:0]   r_id,
  output logic              r_valid,
  input  logic              r_ready
);

  logic                 wr_busy;
  logic                 rd_busy;
  logic [num_banks-1:0] bank_wr_en;
  logic [row_w-1:0]     bank_wr_row;
  logic [data_w-1:0]    bank_wr_data;
  logic                 bank_rd_en;
  logic [row_w-1:0]     bank_rd_row;
  logic [data_w-1:0]    bank_rd_data [num_banks];

  axi_write_engine i_write_engine (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .aw_addr      (aw_addr),
    .aw_len       (aw_len),
    .aw_burst     (aw_burst),
    .aw_id        (aw_id),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w_data       (w_data),
    .w_last       (w_last),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b_resp       (b_resp),
    .b_id         (b_id),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .rd_busy      (rd_busy),
    .wr_busy      (wr_busy),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data)
  );

  axi_read_engine i_read_engine (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .ar_addr      (ar_addr),
    .ar_len       (ar_len),
    .ar_burst     (ar_burst),
    .ar_id        (ar_id),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r_data       (r_data),
    .r_resp       (r_resp),
    .r_last       (r_last),
    .r_id         (r_id),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .wr_busy      (wr_busy),
    .rd_busy      (rd_busy),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_row  (bank_rd_row),
    .bank_rd_data (bank_rd_data)
  );

  // word i of each 16 byte row lives in bank i
  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    buffer_bank i_bank (
      .aclk    (aclk),
      .wr_en   (bank_wr_en[i]),
      .wr_row  (bank_wr_row),
      .wr_data (bank_wr_data),
      .rd_en   (bank_rd_en),
      .rd_row  (bank_rd_row),
      .rd_data (bank_rd_data[i])
    );
  end

endmodule

// File: verilog/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
  import axi_pkg::*, buffer_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  input  buf_addr_t         ar_addr,
  input  logic [len_w-1:0]  ar_len,
  input  burst_t            ar_burst,
  input  logic [id_w-1:0]   ar_id,
  input  logic              ar_valid,
  output logic              ar_ready,
  output logic [data_w-1:0] r_data,
  output resp_t             r_resp,
  output logic              r_last,
  output logic [id_w-1:0]   r_id,
  output logic              r_valid,
  input  logic              r_ready,
  input  logic              wr_busy,
  output logic              rd_busy,
  output logic              bank_rd_en,
  output logic [row_w-1:0]  bank_rd_row,
  input  logic [data_w-1:0] bank_rd_data [num_banks]
);

  buf_addr_t         rd_addr;
  logic [len_w-1:0]  rd_len;
  burst_t            rd_burst;
  logic [len_w-1:0]  beat_cnt;
  logic [bank_w-1:0] rd_bank;
  logic              fetching;
  logic              r_beat;

  // FSM: idle, fetch (one cycle bank read), present (r_valid until r_ready)
  assign rd_busy = ar_ready || fetching || r_valid;
  assign r_beat  = r_valid && r_ready;

  assign r_resp = resp_okay;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_ready <= 1'b0;
      fetching <= 1'b0;
      r_valid  <= 1'b0;
      r_last   <= 1'b0;
    end else begin
      ar_ready <= 1'b0;
      if (ar_ready && ar_valid) begin
        fetching <= 1'b1;
      end else if (!rd_busy && ar_valid && !wr_busy) begin
        ar_ready <= 1'b1;
      end
      // bank data is registered now, present it
      if (fetching) begin
        fetching <= 1'b0;
        r_valid  <= 1'b1;
        r_last   <= (beat_cnt == rd_len);
      end
      if (r_beat) begin
        r_valid  <= 1'b0;
        r_last   <= 1'b0;
        fetching <= !r_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_ready && ar_valid) begin
      rd_addr  <= ar_addr;
      rd_len   <= ar_len;
      rd_burst <= ar_burst;
      r_id     <= ar_id;
      beat_cnt <= '0;
    end else if (r_beat) begin
      rd_addr.flat <= next_beat_addr(rd_addr.flat, rd_burst, rd_len);
      beat_cnt     <= beat_cnt + 1'b1;
    end
  end

  // remember which bank answers the pending fetch
  always_ff @(posedge aclk) begin
    if (fetching) begin
      rd_bank <= rd_addr.f.bank;
    end
  end

  // every bank reads the same row, the mux picks one
  assign bank_rd_en  = fetching;
  assign bank_rd_row = rd_addr.f.row;
  assign r_data      = bank_rd_data[rd_bank];

endmodule

// File: verilog/buffer_bank.sv
`timescale 1ns/1ps

module buffer_bank
  import axi_pkg::*, buffer_pkg::*;
(
  input  logic              aclk,
  input  logic              wr_en,
  input  logic [row_w-1:0]  wr_row,
  input  logic [data_w-1:0] wr_data,
  input  logic              rd_en,
  input  logic [row_w-1:0]  rd_row,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [bank_depth];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // one cycle read, output holds between reads
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];
    end
  end

endmodule

// File: verilog/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
  import axi_pkg::*, buffer_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  buf_addr_t            aw_addr,
  input  logic [len_w-1:0]     aw_len,
  input  burst_t               aw_burst,
  input  logic [id_w-1:0]      aw_id,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  logic [data_w-1:0]    w_data,
  input  logic                 w_last,
  input  logic                 w_valid,
  output logic                 w_ready,
  output resp_t                b_resp,
  output logic [id_w-1:0]      b_id,
  output logic                 b_valid,
  input  logic                 b_ready,
  input  logic                 rd_busy,
  output logic                 wr_busy,
  output logic [num_banks-1:0] bank_wr_en,
  output logic [row_w-1:0]     bank_wr_row,
  output logic [data_w-1:0]    bank_wr_data
);

  buf_addr_t        wr_addr;
  logic [len_w-1:0] wr_len;
  burst_t           wr_burst;
  logic             wr_idle;
  logic             w_beat;

  // FSM state lives in the handshake flags
  // idle: neither, data: w_ready, response: b_valid
  assign wr_idle = !aw_ready && !w_ready && !b_valid;
  assign w_beat  = w_ready && w_valid;

  // a pending aw_valid already counts, so writes win a tie with reads
  assign wr_busy = aw_valid || !wr_idle;

  assign b_resp = resp_okay;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      // single cycle ready pulse
      aw_ready <= 1'b0;
      if (aw_ready && aw_valid) begin
        w_ready <= 1'b1;
      end else if (wr_idle && aw_valid && !rd_busy) begin
        aw_ready <= 1'b1;
      end
      if (w_beat && w_last) begin
        w_ready <= 1'b0;
        b_valid <= 1'b1;
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // burst fields, stepped once per accepted beat
  always_ff @(posedge aclk) begin
    if (aw_ready && aw_valid) begin
      wr_addr  <= aw_addr;
      wr_len   <= aw_len;
      wr_burst <= aw_burst;
      b_id     <= aw_id;
    end else if (w_beat) begin
      wr_addr.flat <= next_beat_addr(wr_addr.flat, wr_burst, wr_len);
    end
  end

  // bank select from the current beat address
  always_comb begin
    for (int i = 0; i < num_banks; i++) begin
      bank_wr_en[i] = w_beat && (wr_addr.f.bank == bank_w'(i));
    end
  end

  assign bank_wr_row  = wr_addr.f.row;
  assign bank_wr_data = w_data;

endmodule

// File: verilog/buffer_pkg.sv
package buffer_pkg;

  // word-interleaved banks
  localparam int num_banks  = 4;
  localparam int bank_w     = 2;
  localparam int bank_depth = 256;
  localparam int row_w      = 8;

  // byte address seen two ways
  // flat for the burst stepping math, fields for bank and row decode
  // top 4 bits are ignored so the buffer repeats every 4 KB
  typedef union packed {
    logic [15:0] flat;
    struct packed {
      logic [3:0]        alias_bits;
      logic [row_w-1:0]  row;
      logic [bank_w-1:0] bank;
      logic [1:0]        offset;
    } f;
  } buf_addr_t;

endpackage

// File: verilog/axi_pkg.sv
package axi_pkg;

  // bus geometry
  localparam int data_w     = 32;
  localparam int addr_w     = 16;
  localparam int id_w       = 4;
  localparam int len_w      = 8;
  localparam int beat_bytes = 4;

  // burst type codes as carried on aw_burst / ar_burst
  typedef logic [1:0] burst_t;

  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr  = 2'b01;
  localparam burst_t burst_wrap  = 2'b10;
  localparam burst_t burst_rsvd  = 2'b11;

  // response codes, only okay is ever returned
  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay = 2'b00;

  // byte address of the beat that follows addr within a burst
  function automatic logic [addr_w-1:0] next_beat_addr(
    input logic [addr_w-1:0] addr,
    input burst_t            burst,
    input logic [len_w-1:0]  len
  );
    logic [addr_w-1:0] aligned;
    logic [addr_w-1:0] incr;
    logic [addr_w-1:0] wrap_mask;
    aligned   = addr & ~addr_w'(beat_bytes - 1);
    incr      = aligned + addr_w'(beat_bytes);
    // wrap block is (len + 1) beats, a power of two for legal wrap bursts
    wrap_mask = (addr_w'(len) + addr_w'(1)) * addr_w'(beat_bytes) - addr_w'(1);
    case (burst)
      burst_fixed: return addr;
      burst_wrap:  return (aligned & ~wrap_mask) | (incr & wrap_mask);
      burst_incr:  return incr;
      // reserved type steps like incr
      default:     return incr;
    endcase
  endfunction

endpackage
